// ==== all.f ====
hw/rv_mem_pkg.sv
hw/axil_pkg.sv
hw/store_lane_former.sv
hw/load_extractor.sv
hw/accessor.sv
hw/mem_stage_top.sv
tests/axil_mem_model.sv
tests/mem_checker.sv
tests/tb_mem_stage.sv

// ==== tests/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;

  logic                  clk;
  logic                  reset;
  logic                  in_valid, in_ready;
  rv_mem_pkg::exec_req_t in_req;
  logic                  out_valid, out_ready;
  rv_mem_pkg::wb_rsp_t   out_rsp;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  logic                  arvalid, arready, rvalid, rready;
  axil_pkg::axil_addr_t  aw, ar;
  axil_pkg::axil_wdata_t w;
  axil_pkg::axil_resp_e  bresp, rresp;
  logic [31:0]           rdata;
  logic [31:0]           lfsr;
  string                 names[$];
  rv_mem_pkg::exec_req_t reqs[$];
  int                    timeouts = 0;

  mem_stage_top UUT (.*);
  axil_mem_model mem (.*);
  mem_checker chk (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // writeback stalls on a random bit per cycle
  always @(posedge clk) begin
    if (reset) begin
      out_ready <= 1'b0;
    end else begin
      lfsr = lfsr_step(lfsr);
      out_ready <= lfsr[0];
    end
  end

  task automatic add_entry(input string name, input rv_mem_pkg::mem_op_e op,
                           input rv_mem_pkg::mem_size_e size, input logic uns,
                           input logic [4:0] rd, input logic [31:0] rd_data,
                           input logic [31:0] addr, input logic [31:0] sdata);
    rv_mem_pkg::exec_req_t r;
    r.op = op;
    r.size = size;
    r.is_unsigned = uns;
    r.rd = rd;
    r.rd_data = rd_data;
    r.addr = addr;
    r.store_data = sdata;
    names.push_back(name);
    reqs.push_back(r);
  endtask

  initial begin
    int   cycles;
    logic done;
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_req = '0;
    out_ready = 1'b0;
    lfsr = 32'd75499;
    add_entry("pass_lui", rv_mem_pkg::MEM_PASS, rv_mem_pkg::SIZE_WORD, 0, 5, 32'h12345000, 0, 0);
    add_entry("sw_0x10", rv_mem_pkg::MEM_STORE, rv_mem_pkg::SIZE_WORD, 0, 7, 0, 32'h10, 32'h80ff7f01);
    add_entry("sb_off0", rv_mem_pkg::MEM_STORE, rv_mem_pkg::SIZE_BYTE, 0, 1, 0, 32'h20, 32'haaaaaa11);
    add_entry("sb_off1", rv_mem_pkg::MEM_STORE, rv_mem_pkg::SIZE_BYTE, 0, 1, 0, 32'h21, 32'h55555582);
    add_entry("sb_off2", rv_mem_pkg::MEM_STORE, rv_mem_pkg::SIZE_BYTE, 0, 1, 0, 32'h22, 32'h0000007f);
    add_entry("sb_off3", rv_mem_pkg::MEM_STORE, rv_mem_pkg::SIZE_BYTE, 0, 1, 0, 32'h23, 32'h123456c3);
    add_entry("sh_off0", rv_mem_pkg::MEM_STORE, rv_mem_pkg::SIZE_HALF, 0, 2, 0, 32'h24, 32'hdead8001);
    add_entry("sh_off2", rv_mem_pkg::MEM_STORE, rv_mem_pkg::SIZE_HALF, 0, 2, 0, 32'h26, 32'hbeef7ffe);
    add_entry("lw_0x10", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_WORD, 0, 10, 0, 32'h10, 0);
    add_entry("lb_off0", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_BYTE, 0, 11, 0, 32'h20, 0);
    add_entry("lb_neg", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_BYTE, 0, 12, 0, 32'h21, 0);
    add_entry("lbu_neg", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_BYTE, 1, 13, 0, 32'h21, 0);
    add_entry("lb_off2", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_BYTE, 0, 14, 0, 32'h22, 0);
    add_entry("lbu_off3", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_BYTE, 1, 15, 0, 32'h23, 0);
    add_entry("lb_off3", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_BYTE, 0, 16, 0, 32'h23, 0);
    add_entry("lh_neg", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_HALF, 0, 17, 0, 32'h24, 0);
    add_entry("lhu_neg", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_HALF, 1, 18, 0, 32'h24, 0);
    add_entry("lh_off2", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_HALF, 0, 19, 0, 32'h26, 0);
    add_entry("lhu_hi", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_HALF, 1, 20, 0, 32'h12, 0);
    add_entry("lb_0x13", rv_mem_pkg::MEM_LOAD, rv_mem_pkg::SIZE_BYTE, 0, 21, 0, 32'h13, 0);
    add_entry("pass_alu", rv_mem_pkg::MEM_PASS, rv_mem_pkg::SIZE_WORD, 0, 31, 32'hfffffffe, 0, 0);
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    foreach (reqs[i]) begin
      if (timeouts == 0) begin
        chk.push_name(names[i]);
        in_valid <= 1'b1;
        in_req <= reqs[i];
        // transfer seen at the edge where in_ready was already high
        done = 1'b0;
        cycles = 0;
        while (!done && cycles < 200) begin
          @(posedge clk);
          done = in_ready;
          cycles++;
        end
        if (!done) begin
          $display("request %s was never accepted", names[i]);
          timeouts++;
        end
      end
    end
    in_valid <= 1'b0;
    cycles = 0;
    while (chk.exp_rsp.size() > 0 && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    if (chk.exp_rsp.size() > 0) begin
      $display("responses still outstanding at end of run");
      timeouts++;
    end
    $display("checks %0d errors %0d timeouts %0d", chk.checks, chk.errors, timeouts);
    if (chk.errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== tests/mem_checker.sv ====
`timescale 1ns/1ps

module mem_checker (
  input var logic                  clk,
  input var logic                  reset,
  input var logic                  in_valid,
  input var logic                  in_ready,
  input var rv_mem_pkg::exec_req_t in_req,
  input var logic                  out_valid,
  input var logic                  out_ready,
  input var rv_mem_pkg::wb_rsp_t   out_rsp,
  input var logic                  awvalid,
  input var logic                  awready,
  input var axil_pkg::axil_addr_t  aw,
  input var logic                  wvalid,
  input var logic                  wready,
  input var axil_pkg::axil_wdata_t w,
  input var logic                  bready,
  input var logic                  arvalid,
  input var logic                  arready,
  input var axil_pkg::axil_addr_t  ar,
  input var logic                  rready
);

  string                 names[$];
  string                 rsp_names[$];
  rv_mem_pkg::wb_rsp_t   exp_rsp[$];
  logic [31:0]           shadow [0:63];
  axil_pkg::axil_wdata_t exp_w;
  logic [31:0]           exp_addr;
  string                 cur_name;
  logic                  accepted_any;
  logic                  stalled;
  rv_mem_pkg::wb_rsp_t   held_rsp;
  int                    wait_cycles;
  int                    errors = 0;
  int                    checks = 0;

  initial begin
    for (int i = 0; i < 64; i++) begin
      shadow[i] = 32'd0;
    end
  end

  // called by the driver before each request goes out
  task automatic push_name(input string name);
    names.push_back(name);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic fail_plain(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // lane by lane, what a store puts on W
  function automatic axil_pkg::axil_wdata_t lane_write(input rv_mem_pkg::exec_req_t r);
    axil_pkg::axil_wdata_t lw;
    for (int l = 0; l < 4; l++) begin
      case (r.size)
        rv_mem_pkg::SIZE_BYTE: begin
          lw.data[8*l +: 8] = r.store_data[7:0];
          lw.strb[l] = (l == r.addr[1:0]);
        end
        rv_mem_pkg::SIZE_HALF: begin
          lw.data[8*l +: 8] = r.store_data[8*(l%2) +: 8];
          lw.strb[l] = (l / 2 == r.addr[1]);
        end
        default: begin
          lw.data[8*l +: 8] = r.store_data[8*l +: 8];
          lw.strb[l] = 1'b1;
        end
      endcase
    end
    return lw;
  endfunction

  function automatic logic [31:0] load_expect(input logic [31:0] word,
                                              input rv_mem_pkg::exec_req_t r);
    logic [31:0] s;
    s = word >> (8 * r.addr[1:0]);
    case (r.size)
      rv_mem_pkg::SIZE_BYTE: begin
        s = s & 32'hff;
        if (!r.is_unsigned && s[7]) s = s | 32'hffffff00;
      end
      rv_mem_pkg::SIZE_HALF: begin
        s = s & 32'hffff;
        if (!r.is_unsigned && s[15]) s = s | 32'hffff0000;
      end
      default: s = word;
    endcase
    return s;
  endfunction

  always @(posedge clk) begin
    rv_mem_pkg::wb_rsp_t   r;
    rv_mem_pkg::wb_rsp_t   got;
    axil_pkg::axil_wdata_t lw;
    logic [5:0]            idx;
    string                 nm;
    if (reset) begin
      accepted_any = 1'b0;
      stalled = 1'b0;
      wait_cycles = 0;
    end else begin
      if (!accepted_any && (out_valid || awvalid || wvalid || arvalid || bready || rready)) begin
        fail_plain("a handshake output went high before any request was accepted");
      end
      if (in_valid && in_ready) begin
        accepted_any = 1'b1;
        wait_cycles = 0;
        cur_name = (names.size() > 0) ? names.pop_front() : "unnamed";
        idx = in_req.addr[7:2];
        // word address expected on aw and ar
        exp_addr = in_req.addr & 32'hfffffffc;
        r = '0;
        case (in_req.op)
          rv_mem_pkg::MEM_STORE: begin
            lw = lane_write(in_req);
            exp_w = lw;
            for (int l = 0; l < 4; l++) begin
              if (lw.strb[l]) shadow[idx][8*l +: 8] = lw.data[8*l +: 8];
            end
          end
          rv_mem_pkg::MEM_LOAD: begin
            r.rd = in_req.rd;
            r.rd_data = load_expect(shadow[idx], in_req);
          end
          default: begin
            r.rd = in_req.rd;
            r.rd_data = in_req.rd_data;
          end
        endcase
        exp_rsp.push_back(r);
        rsp_names.push_back(cur_name);
      end
      if (awvalid && awready) check_value(cur_name, "aw addr", exp_addr, aw.addr);
      if (arvalid && arready) check_value(cur_name, "ar addr", exp_addr, ar.addr);
      if (wvalid && wready) begin
        check_value(cur_name, "w strb", {28'd0, exp_w.strb}, {28'd0, w.strb});
        check_value(cur_name, "w data", exp_w.data, w.data);
      end
      if (in_ready && out_valid) fail_plain("in_ready was high while a response waited");
      if (stalled) begin
        if (!out_valid) fail_plain("out_valid dropped while writeback stalled");
        check_value(cur_name, "stalled rd", {27'd0, held_rsp.rd}, {27'd0, out_rsp.rd});
        check_value(cur_name, "stalled rd_data", held_rsp.rd_data, out_rsp.rd_data);
      end
      stalled = out_valid && !out_ready;
      held_rsp = out_rsp;
      if (out_valid && out_ready) begin
        wait_cycles = 0;
        if (exp_rsp.size() == 0) begin
          fail_plain("writeback got a response with no request behind it");
        end else begin
          r = exp_rsp.pop_front();
          nm = rsp_names.pop_front();
          got = out_rsp;
          check_value(nm, "rd", {27'd0, r.rd}, {27'd0, got.rd});
          check_value(nm, "rd_data", r.rd_data, got.rd_data);
        end
      end else if (exp_rsp.size() > 0) begin
        wait_cycles++;
        if (wait_cycles > 100) begin
          nm = rsp_names.pop_front();
          void'(exp_rsp.pop_front());
          fail_plain({"no response reached writeback for ", nm});
          wait_cycles = 0;
        end
      end
    end
  end

endmodule

// ==== tests/axil_mem_model.sv ====
`timescale 1ns/1ps

module axil_mem_model (
  input  var logic                  clk,
  input  var logic                  reset,
  input  var logic                  awvalid,
  output var logic                  awready,
  input  var axil_pkg::axil_addr_t  aw,
  input  var logic                  wvalid,
  output var logic                  wready,
  input  var axil_pkg::axil_wdata_t w,
  output var logic                  bvalid,
  input  var logic                  bready,
  output var axil_pkg::axil_resp_e  bresp,
  input  var logic                  arvalid,
  output var logic                  arready,
  input  var axil_pkg::axil_addr_t  ar,
  output var logic                  rvalid,
  input  var logic                  rready,
  output var logic [31:0]           rdata,
  output var axil_pkg::axil_resp_e  rresp
);

  logic [31:0] mem [0:63];
  logic [31:0] lfsr;
  logic [1:0]  aw_cnt, w_cnt, b_cnt, ar_cnt, r_cnt;
  logic        aw_got, w_got, ar_got;
  logic [5:0]  waddr, raddr;
  axil_pkg::axil_wdata_t wbuf;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // two lfsr steps, one bit kept from each
  function automatic logic [1:0] draw_delay();
    logic [1:0] d;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_step(lfsr);
      d[i] = lfsr[0];
    end
    return d;
  endfunction

  initial begin
    lfsr = 32'd75499;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = 32'd0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'd0;
    end
  end

  assign bresp = axil_pkg::RESP_OKAY;
  assign rresp = axil_pkg::RESP_OKAY;

  always @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      ar_got  <= 1'b0;
      aw_cnt  <= 2'd0;
      w_cnt   <= 2'd0;
      b_cnt   <= 2'd0;
      ar_cnt  <= 2'd0;
      r_cnt   <= 2'd0;
    end else begin
      // write address
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_got  <= 1'b1;
        waddr   <= aw.addr[7:2];
        aw_cnt  <= draw_delay();
      end else if (awvalid && !aw_got) begin
        if (aw_cnt == 0) awready <= 1'b1;
        else aw_cnt <= aw_cnt - 1;
      end
      // write data
      if (wvalid && wready) begin
        wready <= 1'b0;
        w_got  <= 1'b1;
        wbuf   <= w;
        w_cnt  <= draw_delay();
      end else if (wvalid && !w_got) begin
        if (w_cnt == 0) wready <= 1'b1;
        else w_cnt <= w_cnt - 1;
      end
      // write response, memory updated when it is raised
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        b_cnt  <= draw_delay();
      end else if (aw_got && w_got && !bvalid) begin
        if (b_cnt == 0) begin
          for (int l = 0; l < 4; l++) begin
            if (wbuf.strb[l]) mem[waddr][8*l +: 8] <= wbuf.data[8*l +: 8];
          end
          bvalid <= 1'b1;
          aw_got <= 1'b0;
          w_got  <= 1'b0;
        end else begin
          b_cnt <= b_cnt - 1;
        end
      end
      // read address
      if (arvalid && arready) begin
        arready <= 1'b0;
        ar_got  <= 1'b1;
        raddr   <= ar.addr[7:2];
        ar_cnt  <= draw_delay();
      end else if (arvalid && !ar_got) begin
        if (ar_cnt == 0) arready <= 1'b1;
        else ar_cnt <= ar_cnt - 1;
      end
      // read data
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        r_cnt  <= draw_delay();
      end else if (ar_got && !rvalid) begin
        if (r_cnt == 0) begin
          rdata  <= mem[raddr];
          rvalid <= 1'b1;
          ar_got <= 1'b0;
        end else begin
          r_cnt <= r_cnt - 1;
        end
      end
    end
  end

endmodule

// ==== hw/mem_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
  input  var logic                   clk,
  input  var logic                   reset,
  input  var logic                   in_valid,
  output var logic                   in_ready,
  input  var rv_mem_pkg::exec_req_t  in_req,
  output var logic                   out_valid,
  input  var logic                   out_ready,
  output var rv_mem_pkg::wb_rsp_t    out_rsp,
  output var logic                   awvalid,
  input  var logic                   awready,
  output var axil_pkg::axil_addr_t   aw,
  output var logic                   wvalid,
  input  var logic                   wready,
  output var axil_pkg::axil_wdata_t  w,
  input  var logic                   bvalid,
  output var logic                   bready,
  input  var axil_pkg::axil_resp_e   bresp,
  output var logic                   arvalid,
  input  var logic                   arready,
  output var axil_pkg::axil_addr_t   ar,
  input  var logic                   rvalid,
  output var logic                   rready,
  input  var logic [31:0]            rdata,
  input  var axil_pkg::axil_resp_e   rresp
);

  rv_mem_pkg::exec_req_t held_req;
  rv_mem_pkg::mem_word_u fetched;
  axil_pkg::axil_wdata_t strobed;
  logic [31:0]           load_value;

  accessor u_accessor (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_req     (in_req),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_rsp    (out_rsp),
    .awvalid    (awvalid),
    .awready    (awready),
    .aw         (aw),
    .wvalid     (wvalid),
    .wready     (wready),
    .w          (w),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .ar         (ar),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .strobed    (strobed),
    .load_value (load_value),
    .held_req   (held_req),
    .fetched    (fetched)
  );

  // both formers work off the held request side by side
  store_lane_former u_store_lane_former (
    .size   (held_req.size),
    .offset (held_req.addr[1:0]),
    .data   (held_req.store_data),
    .wdata  (strobed)
  );

  load_extractor u_load_extractor (
    .word        (fetched),
    .size        (held_req.size),
    .is_unsigned (held_req.is_unsigned),
    .offset      (held_req.addr[1:0]),
    .value       (load_value)
  );

endmodule

`default_nettype wire

// ==== hw/accessor.sv ====
`timescale 1ns/1ps
`default_nettype none

module accessor (
  input  var logic                   clk,
  input  var logic                   reset,
  // execute side
  input  var logic                   in_valid,
  output var logic                   in_ready,
  input  var rv_mem_pkg::exec_req_t  in_req,
  // writeback side
  output var logic                   out_valid,
  input  var logic                   out_ready,
  output var rv_mem_pkg::wb_rsp_t    out_rsp,
  // axi write address and data
  output var logic                   awvalid,
  input  var logic                   awready,
  output var axil_pkg::axil_addr_t   aw,
  output var logic                   wvalid,
  input  var logic                   wready,
  output var axil_pkg::axil_wdata_t  w,
  // axi write response
  input  var logic                   bvalid,
  output var logic                   bready,
  input  var axil_pkg::axil_resp_e   bresp,
  // axi read
  output var logic                   arvalid,
  input  var logic                   arready,
  output var axil_pkg::axil_addr_t   ar,
  input  var logic                   rvalid,
  output var logic                   rready,
  input  var logic [31:0]            rdata,
  input  var axil_pkg::axil_resp_e   rresp,
  // lane formers
  input  var axil_pkg::axil_wdata_t  strobed,
  input  var logic [31:0]            load_value,
  output var rv_mem_pkg::exec_req_t  held_req,
  output var rv_mem_pkg::mem_word_u  fetched
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WRESP,
    ST_RADDR,
    ST_RDATA,
    ST_DELIVER
  } state_e;

  state_e state;

  logic accept;
  logic aw_done;
  logic w_done;
  logic [31:0] word_addr;

  assign accept = in_valid && in_ready;

  // a channel is done once its valid is gone or its handshake is now
  assign aw_done = !awvalid || awready;
  assign w_done  = !wvalid || wready;

  assign word_addr = {held_req.addr[31:2], 2'b00};

  // error responses are not acted on, bresp and rresp pass unused
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      in_ready  <= 1'b0;
      out_valid <= 1'b0;
      awvalid   <= 1'b0;
      wvalid    <= 1'b0;
      bready    <= 1'b0;
      arvalid   <= 1'b0;
      rready    <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            in_ready <= 1'b0;
            case (in_req.op)
              rv_mem_pkg::MEM_STORE: begin
                state   <= ST_WRITE;
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
              end
              rv_mem_pkg::MEM_LOAD: begin
                state   <= ST_RADDR;
                arvalid <= 1'b1;
              end
              default: begin
                state     <= ST_DELIVER;
                out_valid <= 1'b1;
              end
            endcase
          end else begin
            in_ready <= 1'b1;
          end
        end
        ST_WRITE: begin
          // aw and w complete independently
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (aw_done && w_done) begin
            state  <= ST_WRESP;
            bready <= 1'b1;
          end
        end
        ST_WRESP: begin
          if (bvalid) begin
            bready    <= 1'b0;
            state     <= ST_DELIVER;
            out_valid <= 1'b1;
          end
        end
        ST_RADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= ST_RDATA;
          end
        end
        ST_RDATA: begin
          if (rvalid) begin
            rready    <= 1'b0;
            state     <= ST_DELIVER;
            out_valid <= 1'b1;
          end
        end
        ST_DELIVER: begin
          // hold until writeback takes it
          if (out_ready) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept) begin
      held_req <= in_req;
    end
    if (rvalid && rready) begin
      fetched <= rv_mem_pkg::mem_word_u'(rdata);
    end
  end

  assign aw.addr = word_addr;
  assign aw.prot = axil_pkg::PROT_DATA;
  assign ar.addr = word_addr;
  assign ar.prot = axil_pkg::PROT_DATA;
  assign w       = strobed;

  always_comb begin
    case (held_req.op)
      rv_mem_pkg::MEM_LOAD: begin
        out_rsp.rd      = held_req.rd;
        out_rsp.rd_data = load_value;
      end
      rv_mem_pkg::MEM_STORE: begin
        // nothing to write back
        out_rsp.rd      = 5'd0;
        out_rsp.rd_data = 32'd0;
      end
      default: begin
        out_rsp.rd      = held_req.rd;
        out_rsp.rd_data = held_req.rd_data;
      end
    endcase
  end

  // response must not change while writeback stalls
  a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_rsp));

  a_one_addr_channel: assert property (@(posedge clk) disable iff (reset)
    !(arvalid && awvalid));

  a_no_accept_while_busy: assert property (@(posedge clk) disable iff (reset)
    !(in_ready && out_valid));

endmodule

`default_nettype wire

// ==== hw/load_extractor.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extractor (
  input  var rv_mem_pkg::mem_word_u word,
  input  var rv_mem_pkg::mem_size_e size,
  input  var logic                  is_unsigned,
  input  var logic [1:0]            offset,
  output var logic [31:0]           value
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  logic        byte_fill;
  logic        half_fill;

  // lane picks through the two views of the word
  assign sel_byte = word.bytes[offset];
  assign sel_half = word.halves[offset[1]];

  // sign bit or zero for the upper bits
  assign byte_fill = !is_unsigned && sel_byte[7];
  assign half_fill = !is_unsigned && sel_half[15];

  always_comb begin
    case (size)
      rv_mem_pkg::SIZE_BYTE: begin
        value = {{24{byte_fill}}, sel_byte};
      end
      rv_mem_pkg::SIZE_HALF: begin
        value = {{16{half_fill}}, sel_half};
      end
      default: begin
        // lw, nothing to extend
        value = word.bytes;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/store_lane_former.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_lane_former (
  input  var rv_mem_pkg::mem_size_e   size,
  input  var logic [1:0]              offset,
  input  var logic [31:0]             data,
  output var axil_pkg::axil_wdata_t   wdata
);

  logic [3:0] byte_strb;
  logic [3:0] half_strb;

  // lane selects for the narrow sizes
  assign byte_strb = 4'b0001 << offset;
  assign half_strb = 4'b0011 << {offset[1], 1'b0};

  always_comb begin
    case (size)
      rv_mem_pkg::SIZE_BYTE: begin
        // same byte on every lane, strobe picks one
        wdata.data = {4{data[7:0]}};
        wdata.strb = byte_strb;
      end
      rv_mem_pkg::SIZE_HALF: begin
        wdata.data = {2{data[15:0]}};
        wdata.strb = half_strb;
      end
      default: begin
        // full word
        wdata.data = data;
        wdata.strb = 4'b1111;
      end
    endcase
  end

  // halves on even offsets, words on offset 0
  always_comb begin
    if (!$isunknown({size, offset})) begin
      assert final (size == rv_mem_pkg::SIZE_BYTE ||
                    (size == rv_mem_pkg::SIZE_HALF && !offset[0]) ||
                    offset == 2'd0)
        else $error("misaligned access, size %0d offset %0d", size, offset);
    end
  end

endmodule

`default_nettype wire

// ==== hw/axil_pkg.sv ====
package axil_pkg;

  // unprivileged, secure, data access
  localparam logic [2:0] PROT_DATA = 3'b000;

  // aw and ar channel payload
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
  } axil_addr_t;

  // w channel payload
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axil_wdata_t;

  // b and r response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_e;

endpackage

// ==== hw/rv_mem_pkg.sv ====
package rv_mem_pkg;

  // kind of work the stage does for one operation
  typedef enum logic [1:0] {
    MEM_PASS  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  // access width, byte/half/word as in lb/lh/lw and sb/sh/sw
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  // record from the execute stage
  typedef struct packed {
    mem_op_e     op;
    mem_size_e   size;
    logic        is_unsigned;
    logic [4:0]  rd;
    // alu or lui result, used by pass ops
    logic [31:0] rd_data;
    logic [31:0] addr;
    logic [31:0] store_data;
  } exec_req_t;

  // record to writeback, stores carry rd 0
  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] rd_data;
  } wb_rsp_t;

  // one fetched memory word, seen as bytes or as halfwords
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

endpackage
